// ==== build.f ====
design/mult_isa_pkg.sv
design/mult_ctrl_pkg.sv
design/mult_int_mac.sv
design/mult_short_unit.sv
design/mulh_sequencer.sv
design/mult_top.sv
tests/tb_clock_gen.sv
tests/mult_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it.
# Exits with status 0 only when the simulation prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module mult_tb -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vmult_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Test passed'; then
  exit 0
fi
exit 1

// ==== tests/mult_tb.sv ====
// Self-checking testbench for mult_top; MUL_H completion is found from the handshake
// Inputs change 2 ns after the rising edge, outputs are sampled on the falling edge
`default_nettype none

module mult_tb
  import mult_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          TIMEOUT_CYCLES = 20;
  localparam int unsigned SEED           = 32'h75db;

  logic            clk;
  logic            rst_n;
  logic            enable;
  logic            ex_ready;
  mult_req_t       req;
  logic [XLEN-1:0] result;
  logic            ready;
  logic            multicycle;

  // Expected result of the outstanding request
  logic [XLEN-1:0] expect_q[$];
  bit              txn_open;
  bit              aborted;
  int              check_count;
  int              error_count;
  int              test_check_start;
  int              test_error_start;
  string           cur_test;

  tb_clock_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mult_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable),
    .req_i        (req),
    .ex_ready_i   (ex_ready),
    .result_o     (result),
    .ready_o      (ready),
    .multicycle_o (multicycle)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Everything in 64 bits, each operand extended before the multiply
  function automatic logic [XLEN-1:0] mult_ref(input mult_req_t r);
    logic [63:0]     a_ext;
    logic [63:0]     b_ext;
    logic [63:0]     sum;
    logic [15:0]     a_half;
    logic [15:0]     b_half;
    logic [XLEN-1:0] low;
    logic [XLEN-1:0] res;
    res = '0;
    case (r.operator)
      MUL_MAC32: begin
        low = r.op_a * r.op_b;
        res = r.op_c + low;
      end
      MUL_MSU32: begin
        low = r.op_a * r.op_b;
        res = r.op_c - low;
      end
      MUL_I, MUL_IR: begin
        a_half = r.short_subword ? r.op_a[31:16] : r.op_a[15:0];
        b_half = r.short_subword ? r.op_b[31:16] : r.op_b[15:0];
        a_ext  = r.short_signed[0] ? {{48{a_half[15]}}, a_half} : {48'b0, a_half};
        b_ext  = r.short_signed[1] ? {{48{b_half[15]}}, b_half} : {48'b0, b_half};
        sum    = a_ext * b_ext + {32'b0, r.op_c};
        // Half an LSB of the shifted result
        if (r.operator == MUL_IR && r.imm != 0) begin
          sum = sum + (64'd1 << (r.imm - 5'd1));
        end
        low = sum[31:0];
        if (r.short_signed[0]) begin
          res = $signed(low) >>> r.imm;
        end else begin
          res = low >> r.imm;
        end
      end
      MUL_H: begin
        a_ext = r.short_signed[0] ? {{32{r.op_a[31]}}, r.op_a} : {32'b0, r.op_a};
        b_ext = r.short_signed[1] ? {{32{r.op_b[31]}}, r.op_b} : {32'b0, r.op_b};
        sum   = a_ext * b_ext;
        res   = sum[63:32];
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic mult_req_t random_req(input mult_op_e op, input logic [1:0] sgn);
    mult_req_t r;
    r.operator      = op;
    r.short_subword = 1'($urandom);
    r.short_signed  = sgn;
    r.op_a          = $urandom;
    r.op_b          = $urandom;
    r.op_c          = $urandom;
    r.imm           = 5'($urandom);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("ERROR %s: expected %h, actual %h", cur_test, exp, act);
    end
  endtask

  task automatic check_flag(input bit ok, input string what);
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("%s: %s", cur_test, what);
    end
  endtask

  task automatic abort_run(input string what);
    aborted = 1'b1;
    $display("%s: timed out, %s", cur_test, what);
  endtask

  task automatic begin_test(input string name);
    cur_test         = name;
    test_check_start = check_count;
    test_error_start = error_count;
  endtask

  task automatic end_test();
    if (aborted) begin
      $display("FAIL %s (stopped by a timeout)", cur_test);
    end else if (error_count == test_error_start) begin
      $display("PASS %s (%0d checks)", cur_test, check_count - test_check_start);
    end else begin
      $display("FAIL %s (%0d of %0d checks failed)", cur_test,
               error_count - test_error_start, check_count - test_check_start);
    end
  endtask

  // Compares every result that leaves through ready_o and ex_ready_i
  always @(negedge clk) begin : compare_results
    logic [XLEN-1:0] exp_val;
    if (rst_n && txn_open && ready && ex_ready) begin
      exp_val = expect_q.pop_front();
      check_value(exp_val, result);
      txn_open = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, each returns on a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_reset_release();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rst_n && n < TIMEOUT_CYCLES);
    if (!rst_n) begin
      abort_run("reset was never released");
    end
  endtask

  task automatic wait_result_taken();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (txn_open && n < TIMEOUT_CYCLES);
    if (txn_open) begin
      abort_run("the result was never taken by the handshake");
    end
  endtask

  task automatic issue(input mult_req_t r, input logic ex_ready_val);
    req      = r;
    enable   = 1'b1;
    ex_ready = ex_ready_val;
    expect_q.push_back(mult_ref(r));
    txn_open = 1'b1;
  endtask

  task automatic run_single(input mult_req_t r);
    if (aborted) return;
    #2;
    issue(r, 1'b1);
    wait_result_taken();
  endtask

  // hold is the number of FINISH cycles with ex_ready_i low
  task automatic run_mulh(input mult_req_t r, input int hold);
    int              busy;
    int              n;
    int              held;
    logic [XLEN-1:0] held_result;
    if (aborted) return;
    #2;
    issue(r, hold == 0);
    @(negedge clk);
    check_flag(!ready && !multicycle, "ready_o did not fall in the accepting cycle");
    @(posedge clk);
    #2;
    enable = 1'b0;
    busy   = 0;
    n      = 0;
    @(negedge clk);
    while (!ready && n < TIMEOUT_CYCLES) begin
      if (multicycle) begin
        busy++;
      end
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      abort_run("ready_o never rose for MUL_H");
      return;
    end
    // Three step cycles, FINISH is the 4th after acceptance
    check_value(32'd3, 32'(busy));
    held_result = result;
    for (held = 1; held < hold; held++) begin
      @(negedge clk);
      check_value(held_result, result);
      check_flag(ready && !multicycle, "ready_o dropped while FINISH was held");
    end
    if (hold > 0) begin
      @(posedge clk);
      #2;
      ex_ready = 1'b1;
    end
    wait_result_taken();
    if (aborted) return;
    @(negedge clk);
    check_flag(ready && !multicycle, "ready_o not high in IDLE after MUL_H");
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_int_mac(input mult_op_e op, input string name);
    int i;
    begin_test(name);
    for (i = 0; i < 64; i++) begin
      run_single(random_req(op, 2'($urandom)));
    end
    end_test();
  endtask

  task automatic test_subword();
    mult_req_t  r;
    logic [1:0] sgn_list [3] = '{2'b00, 2'b01, 2'b11};
    int         o;
    int         sub;
    int         s;
    int         sh;
    begin_test("mul_i_ir");
    for (o = 0; o < 2; o++) begin
      for (sub = 0; sub < 2; sub++) begin
        for (s = 0; s < 3; s++) begin
          for (sh = 0; sh < 32; sh++) begin
            r               = random_req((o == 0) ? MUL_I : MUL_IR, sgn_list[s]);
            r.short_subword = sub[0];
            r.imm           = sh[4:0];
            run_single(r);
          end
        end
      end
    end
    end_test();
  endtask

  task automatic test_mulh();
    mult_req_t       r;
    logic [1:0]      sgn_list [3] = '{2'b11, 2'b01, 2'b00};
    logic [XLEN-1:0] corner_a [3] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    logic [XLEN-1:0] corner_b [3] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0001};
    int              s;
    int              k;
    begin_test("mul_h");
    for (s = 0; s < 3; s++) begin
      // Extreme operands first, they stress the carries between steps
      for (k = 0; k < 3; k++) begin
        r      = random_req(MUL_H, sgn_list[s]);
        r.op_a = corner_a[k];
        r.op_b = corner_b[k];
        run_mulh(r, 0);
      end
      for (k = 0; k < 6; k++) begin
        run_mulh(random_req(MUL_H, sgn_list[s]), 0);
      end
    end
    end_test();
  endtask

  task automatic test_backpressure();
    logic [1:0] sgn_list [3] = '{2'b11, 2'b01, 2'b00};
    int         i;
    begin_test("mul_h_backpressure");
    for (i = 0; i < 12; i++) begin
      run_mulh(random_req(MUL_H, sgn_list[$urandom % 3]), int'($urandom % 6));
    end
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    enable      = 1'b0;
    ex_ready    = 1'b1;
    req         = '0;
    txn_open    = 1'b0;
    aborted     = 1'b0;
    check_count = 0;
    error_count = 0;

    begin_test("reset");
    wait_reset_release();
    if (!aborted) begin
      @(negedge clk);
      check_flag(ready && !multicycle, "ready_o low or multicycle_o high after reset");
      @(posedge clk);
    end
    end_test();

    test_int_mac(MUL_MAC32, "mul_mac32");
    test_int_mac(MUL_MSU32, "mul_msu32");
    test_subword();
    test_mulh();
    test_backpressure();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (aborted || error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Free-running 20 ns clock for the multiplier testbench
// Reset is held low for the first 10 rising edges, then released 2 ns after an edge
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;

  // 10 ns high, 10 ns low
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Released away from the edge so no flop sees it change at the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/mult_top.sv ====
// Multiplier top; single-cycle ops are combinational, MUL_H takes 4 cycles
// Handshake: accept on enable_i with ready_o, release on ready_o with ex_ready_i
`default_nettype none

module mult_top
  import mult_isa_pkg::*;
  import mult_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_req_t         req_i,
  input  logic              ex_ready_i,
  output logic [XLEN-1:0]   result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  logic            is_mulh_start;
  mulh_step_t      mulh_step;
  logic [XLEN-1:0] short_result;
  logic [XLEN-1:0] int_result;

  // Only MUL_H needs the sequencer, everything else completes in place
  assign is_mulh_start = enable_i && (req_i.operator == MUL_H);

  ////////////////////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////////////////////

  mulh_sequencer u_mulh_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (is_mulh_start),
    .signed_i     (req_i.short_signed),
    .ex_ready_i   (ex_ready_i),
    .step_o       (mulh_step),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  mult_short_unit u_short (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_i),
    .step_i   (mulh_step),
    .result_o (short_result)
  );

  mult_int_mac u_int_mac (
    .req_i    (req_i),
    .result_o (int_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    unique case (req_i.operator)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      // Unused codes read as zero
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/mulh_sequencer.sv ====
// Steps MUL_H through four 16x16 partial products over four cycles
// Request must stay stable from acceptance until FINISH is left
`default_nettype none

module mulh_sequencer
  import mult_isa_pkg::*;
  import mult_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic [1:0]  signed_i,
  input  logic        ex_ready_i,
  output mulh_step_t  step_o,
  output logic        ready_o,
  output logic        multicycle_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and step controls
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    step_o       = '0;
    step_o.active = 1'b1;
    ready_o      = 1'b0;
    multicycle_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        step_o.active = 1'b0;
        // Ready drops in the accepting cycle
        ready_o = !start_i;
        if (start_i) begin
          state_d = STEP0;
        end
      end

      STEP0: begin
        // AL*BL, both unsigned, keep only the upper half
        multicycle_o = 1'b1;
        step_o.imm   = 5'(HALF_W);
        step_o.save  = 1'b1;
        state_d      = STEP1;
      end

      STEP1: begin
        // AL*BH is signed iff B is signed
        multicycle_o       = 1'b1;
        step_o.subword     = 2'b10;
        step_o.signed_sel  = {signed_i[1], 1'b0};
        step_o.shift_arith = 1'b1;
        // No shift, the 33-bit sum with its carry is stored
        step_o.save        = 1'b1;
        state_d            = STEP2;
      end

      STEP2: begin
        // AH*BL is signed iff A is signed
        multicycle_o       = 1'b1;
        step_o.subword     = 2'b01;
        step_o.signed_sel  = {1'b0, signed_i[0]};
        step_o.shift_arith = 1'b1;
        step_o.imm         = 5'(HALF_W);
        step_o.save        = 1'b1;
        state_d            = FINISH;
      end

      FINISH: begin
        // AH*BH plus partial gives the high word, held until taken
        step_o.subword    = 2'b11;
        step_o.signed_sel = signed_i;
        ready_o           = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        step_o.active = 1'b0;
        state_d       = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Every step and FINISH read signed_i so the source holds it until release
  a_signed_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q != IDLE) |-> $stable(signed_i)
  ) else $error("signed_i changed while MUL_H was in progress");

endmodule

`default_nettype wire

// ==== design/mult_short_unit.sv ====
// Subword MAC with rounding and right shift; also runs the MUL_H steps
// The partial-sum register is only meaningful while step_i.active is high
`default_nettype none

module mult_short_unit
  import mult_isa_pkg::*;
  import mult_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  mult_req_t         req_i,
  input  mulh_step_t        step_i,
  output logic [XLEN-1:0]   result_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Control select
  ////////////////////////////////////////////////////////////////////////////

  logic [4:0]          short_imm;
  logic [1:0]          short_subword;
  logic [1:0]          short_signed;
  logic                short_shift_arith;

  // Sequencer controls take over for the duration of MUL_H
  assign short_imm         = step_i.active ? step_i.imm : req_i.imm;
  assign short_subword     = step_i.active ? step_i.subword : {2{req_i.short_subword}};
  assign short_signed      = step_i.active ? step_i.signed_sel : req_i.short_signed;
  assign short_shift_arith = step_i.active ? step_i.shift_arith : req_i.short_signed[0];

  ////////////////////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////////////////////

  logic [HALF_W:0]     short_op_a;
  logic [HALF_W:0]     short_op_b;
  logic [XLEN:0]       short_op_c;
  logic [XLEN:0]       partial_q;
  logic [XLEN-1:0]     round_tmp;
  logic [XLEN-1:0]     short_round;

  // Half selection
  assign short_op_a[HALF_W-1:0] = short_subword[0] ? req_i.op_a[XLEN-1:HALF_W]
                                                   : req_i.op_a[HALF_W-1:0];
  assign short_op_b[HALF_W-1:0] = short_subword[1] ? req_i.op_b[XLEN-1:HALF_W]
                                                   : req_i.op_b[HALF_W-1:0];

  // 17th bit turns each half into a signed or unsigned value
  assign short_op_a[HALF_W] = short_signed[0] & short_op_a[HALF_W-1];
  assign short_op_b[HALF_W] = short_signed[1] & short_op_b[HALF_W-1];

  // MUL_H accumulates into its own partial sum, op_c is sign extended otherwise
  assign short_op_c = step_i.active ? partial_q : {req_i.op_c[XLEN-1], req_i.op_c};

  // Half an LSB of the shifted result, nothing when imm is 0
  assign round_tmp   = {{(XLEN-1){1'b0}}, 1'b1} << req_i.imm;
  assign short_round = (req_i.operator == MUL_IR) ? {1'b0, round_tmp[XLEN-1:1]} : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Multiply, accumulate, shift
  ////////////////////////////////////////////////////////////////////////////

  logic [2*HALF_W+1:0] short_mul;
  logic [XLEN+1:0]     short_mac;
  logic [XLEN+1:0]     short_result;
  logic                mac_msb1;
  logic                mac_msb0;

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = $signed(short_op_c) + $signed(short_mul) + $signed(short_round);

  // MUL_H keeps the two carry bits of the wider sum, plain ops replicate bit 31
  assign mac_msb1 = step_i.active ? short_mac[XLEN+1] : short_mac[XLEN-1];
  assign mac_msb0 = step_i.active ? short_mac[XLEN]   : short_mac[XLEN-1];

  assign short_result = $signed({short_shift_arith & mac_msb1,
                                 short_shift_arith & mac_msb0,
                                 short_mac[XLEN-1:0]}) >>> short_imm;

  assign result_o = short_result[XLEN-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // MUL_H partial sum
  ////////////////////////////////////////////////////////////////////////////

  // Bit 32 is the carry of STEP1 and the sign after the STEP2 shift
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial_q <= '0;
    end else if (!step_i.active) begin
      // STEP0 must start from zero
      partial_q <= '0;
    end else if (step_i.save) begin
      partial_q <= short_result[XLEN:0];
    end
  end

  // Unsigned A with signed B is not encodable since the shift follows bit 0 only
  a_short_signed_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!step_i.active && (req_i.operator inside {MUL_I, MUL_IR}))
      |-> (req_i.short_signed != 2'b10)
  ) else $error("illegal short_signed 2'b10 on a subword operation");

endmodule

`default_nettype wire

// ==== design/mult_int_mac.sv ====
// 32x32 multiply with accumulate or subtract; only the low XLEN bits are kept
// Purely combinational, the result is valid in the request cycle
`default_nettype none

module mult_int_mac
  import mult_isa_pkg::*;
(
  input  mult_req_t         req_i,
  output logic [XLEN-1:0]   result_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Subtract correction
  ////////////////////////////////////////////////////////////////////////////

  logic            is_msu;
  logic [XLEN-1:0] op_a_msu;
  logic [XLEN-1:0] op_b_corr;
  logic [XLEN-1:0] product;

  // High for c - a*b
  assign is_msu = (req_i.operator == MUL_MSU32);

  // ~a * b + b == -(a * b), so one multiplier serves both operations
  assign op_a_msu  = req_i.op_a ^ {XLEN{is_msu}};
  // Correction term is zero for the accumulate case
  assign op_b_corr = req_i.op_b & {XLEN{is_msu}};

  ////////////////////////////////////////////////////////////////////////////
  // Multiply and accumulate
  ////////////////////////////////////////////////////////////////////////////

  // Signedness does not matter for the low half of the product
  assign product = op_a_msu * req_i.op_b;

  // Wraps modulo 2^XLEN
  assign result_o = req_i.op_c + op_b_corr + product;

endmodule

`default_nettype wire

// ==== design/mult_ctrl_pkg.sv ====
// Control types shared between the MUL_H sequencer and the subword datapath
`default_nettype none

package mult_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////////////////////////////////////////

  // Three partial-product steps, then FINISH forms the result
  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Per-step control
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // Overrides the request controls in the subword unit
    logic       active;
    // Bit 0 picks the A half, bit 1 the B half; 1 means upper half
    logic [1:0] subword;
    // Bit 0 for A, bit 1 for B
    logic [1:0] signed_sel;
    logic       shift_arith;
    logic [4:0] imm;
    // Load the partial-sum register at the next edge
    logic       save;
  } mulh_step_t;

endpackage

`default_nettype wire

// ==== design/mult_isa_pkg.sv ====
// Operation encodings and request layout seen at the multiplier boundary
// Operand widths are architectural; the subword unit assumes XLEN == 2 * HALF_W
`default_nettype none

package mult_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Full operand width
  localparam int unsigned XLEN   = 32;
  // Subword width used by MUL_I, MUL_IR and the MUL_H steps
  localparam int unsigned HALF_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  // Codes 3'b100, 3'b101 and 3'b111 are unused and give a zero result
  typedef enum logic [2:0] {
    // c + a*b, low 32 bits
    MUL_MAC32 = 3'b000,
    // c - a*b, low 32 bits
    MUL_MSU32 = 3'b001,
    // Subword multiply with accumulate and shift
    MUL_I     = 3'b010,
    // Same as MUL_I with rounding before the shift
    MUL_IR    = 3'b011,
    // Upper half of the 64-bit product, multicycle
    MUL_H     = 3'b110
  } mult_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    mult_op_e          operator;
    // Selects the high halves of A and B for the subword ops
    logic              short_subword;
    // Bit 0 for A, bit 1 for B; 2'b10 is not a legal combination
    logic [1:0]        short_signed;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    // Accumulator, free for software also during MUL_H
    logic [XLEN-1:0]   op_c;
    // Right shift amount for the subword ops
    logic [4:0]        imm;
  } mult_req_t;

endpackage

`default_nettype wire
